// ==== icache_patterns.txt ====
# columns: op addr(hex) uncache code flush mem
# code 0 store-tag 1 index-invalidate 2 hit-invalidate, mem 1 when a memory read is expected
fetch 00001010 0 0 0 1
fetch 00001018 0 0 0 0
fetch 00002020 0 0 0 1
fetch 00003024 0 0 0 1
fetch 00002028 0 0 0 0
fetch 00004020 0 0 0 1
fetch 0000202c 0 0 0 0
fetch 00003020 0 0 0 1
fetch 00005038 1 0 0 1
fetch 0000503c 1 0 0 1
fetch 00006042 0 0 0 0
fetch 00001011 0 0 0 0
fetch 00007050 0 0 0 1
cacop 00007051 0 1 0 0
fetch 00007050 0 0 0 1
fetch 00007058 0 0 0 0
cacop 00007050 0 2 0 0
fetch 00007054 0 0 0 1
fetch 00008060 0 0 0 1
cacop 00008061 0 0 0 0
fetch 00008060 0 0 0 1
fetch 00009070 0 0 1 1
fetch 00009078 0 0 0 0

// ==== icache.f ====
+incdir+.
icache_pkg.sv
icache_ctrl_pkg.sv
icache_ctrl_if.sv
icache_sram.sv
icache_lru.sv
icache_datapath.sv
icache_ctrl.sv
icache_top.sv
tb_clkgen.sv
tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - include_dirs:
      - .
    files:
      - icache_pkg.sv
      - icache_ctrl_pkg.sv
      - icache_ctrl_if.sv
      - icache_sram.sv
      - icache_lru.sv
      - icache_datapath.sv
      - icache_ctrl.sv
      - icache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clkgen.sv
      - tb_icache.sv

// ==== tb_icache.sv ====
`timescale 1ns/10ps
`include "icache_consts.svh"

module tb_icache import icache_pkg::*, icache_ctrl_pkg::*; ();

    localparam int    DRIVE_DLY = 2;              // ns after the rising edge
    localparam addr_t FILL_KEY  = 32'h5a5a_0000;  // memory word = address ^ key

    logic        clk;
    logic        rstn;
    logic        i_req_valid;
    addr_t       i_req_addr;
    logic        i_uncache;
    logic        i_flush;
    logic        i_cacop_en;
    cacop_t      i_cacop_code;
    logic        i_mem_rready;
    line_t       i_mem_rdata;
    logic        o_req_ready;
    dword_t      o_rdata;
    addr_t       o_pc;
    exc_t        o_exc;
    addr_t       o_badv;
    logic        o_idle;
    logic        o_mem_rvalid;
    addr_t       o_mem_raddr;
    logic [7:0]  o_mem_rlen;
    logic        o_cacop_ready;
    logic        o_cacop_complete;

    // one entry per pattern line
    logic        is_cacop_q[$];
    addr_t       addr_q[$];
    logic        unc_q[$];
    cacop_t      code_q[$];
    logic        flush_q[$];
    logic        mem_q[$];
    logic        loaded = 1'b0;
    logic [31:0] lfsr = 32'h581c;

    tb_clkgen #(.PERIOD_NS(100), .RESET_CYCLES(3)) tb_clkgen_i (
        .clk  (clk),
        .rstn (rstn)
    );

    icache_top icache_top_i (
        .clk              (clk),
        .rstn             (rstn),
        .i_req_valid      (i_req_valid),
        .i_req_addr       (i_req_addr),
        .i_uncache        (i_uncache),
        .i_flush          (i_flush),
        .o_req_ready      (o_req_ready),
        .o_rdata          (o_rdata),
        .o_pc             (o_pc),
        .o_exc            (o_exc),
        .o_badv           (o_badv),
        .o_idle           (o_idle),
        .i_cacop_en       (i_cacop_en),
        .i_cacop_code     (i_cacop_code),
        .o_cacop_ready    (o_cacop_ready),
        .o_cacop_complete (o_cacop_complete),
        .o_mem_rvalid     (o_mem_rvalid),
        .i_mem_rready     (i_mem_rready),
        .o_mem_raddr      (o_mem_raddr),
        .o_mem_rlen       (o_mem_rlen),
        .i_mem_rdata      (i_mem_rdata)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic line_t fill_line(input addr_t base);
        line_t l;
        for (int i = 0; i < 4; i++) begin
            l[32*i +: 32] = (base + 32'(4 * i)) ^ FILL_KEY;
        end
        return l;
    endfunction

    // the two words of the doubleword holding addr
    function automatic dword_t word_pair(input addr_t addr);
        addr_t base;
        base = {addr[31:3], 3'b000};
        return {(base + 32'd4) ^ FILL_KEY, base ^ FILL_KEY};
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_dword(input dword_t got, input dword_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_exc(input exc_t got, input exc_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0d ns: %s, got %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic load_patterns();
        int            fd;
        int            n;
        logic [127:0]  word;
        logic [1023:0] rest;
        addr_t         f_addr;
        logic          f_unc;
        int            f_code;
        logic          f_flush;
        logic          f_mem;
        fd = $fopen("icache_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open icache_patterns.txt for reading");
            abort_run();
        end
        while (!$feof(fd)) begin
            word = '0;
            n = $fscanf(fd, "%s", word);
            if (n == 1) begin
                if (word == "#") begin
                    n = $fgets(rest, fd); // comment line
                end else if (word == "fetch" || word == "cacop") begin
                    n = $fscanf(fd, "%h %b %d %b %b", f_addr, f_unc, f_code, f_flush, f_mem);
                    if (n != 5) begin
                        $display("Pattern line for %0s has missing or bad fields", word);
                        abort_run();
                    end
                    is_cacop_q.push_back(word == "cacop");
                    addr_q.push_back(f_addr);
                    unc_q.push_back(f_unc);
                    code_q.push_back(cacop_t'(f_code[1:0]));
                    flush_q.push_back(f_flush);
                    mem_q.push_back(f_mem);
                end else begin
                    $display("Unknown operation %0s in icache_patterns.txt", word);
                    abort_run();
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (!o_idle) begin
            @(negedge clk);
        end
    endtask

    task automatic run_fetch(input addr_t addr, input logic unc, input logic flush,
                             input logic exp_mem);
        logic  mem_seen;
        logic  done;
        addr_t exp_raddr;
        mem_seen  = 1'b0;
        done      = 1'b0;
        exp_raddr = unc ? {addr[31:3], 3'b000} : {addr[31:4], 4'b0000};
        wait_idle();
        @(posedge clk);
        #DRIVE_DLY;
        i_req_valid = 1'b1;
        i_req_addr  = addr;
        i_uncache   = unc;
        @(posedge clk); // accepted, cache was idle
        #DRIVE_DLY;
        i_req_valid = 1'b0;
        i_uncache   = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (o_mem_rvalid && !mem_seen) begin
                mem_seen = 1'b1;
                check_addr(o_mem_raddr, exp_raddr, "memory read address");
                check_flag(o_mem_rlen == 8'd0, 1'b1, "memory read length is zero");
                if (flush) begin // one flush cycle while the miss waits
                    @(posedge clk);
                    #DRIVE_DLY;
                    i_flush = 1'b1;
                    @(posedge clk);
                    #DRIVE_DLY;
                    i_flush = 1'b0;
                end
            end else if (o_req_ready) begin
                check_flag(flush, 1'b0, "response after a flushed miss");
                check_addr(o_pc, addr, "fetch pc");
                if (addr[1:0] != 2'b00) begin
                    check_exc(o_exc, EXC_ADEF, "exception code");
                    check_dword(o_rdata, {`ICACHE_NOP, `ICACHE_NOP}, "nop pair on exception");
                    check_addr(o_badv, addr, "bad address");
                end else begin
                    check_exc(o_exc, EXC_NONE, "exception code");
                    check_dword(o_rdata, word_pair(addr), "fetch data");
                end
                done = 1'b1;
            end else if (o_idle) begin
                check_flag(flush, 1'b1, "fetch ended without a response");
                done = 1'b1;
            end
        end
        check_flag(mem_seen, exp_mem, "memory request made");
    endtask

    task automatic run_cacop(input addr_t addr, input cacop_t code);
        wait_idle();
        @(posedge clk);
        #DRIVE_DLY;
        i_cacop_en   = 1'b1;
        i_req_addr   = addr;
        i_cacop_code = code;
        @(negedge clk);
        check_flag(o_cacop_ready, 1'b1, "cacop ready in the accept cycle");
        check_flag(o_cacop_complete, 1'b0, "cacop complete together with ready");
        @(posedge clk);
        #DRIVE_DLY;
        i_cacop_en = 1'b0;
        @(negedge clk);
        check_flag(o_cacop_complete, 1'b1, "cacop complete one cycle after ready");
        check_flag(o_cacop_ready, 1'b0, "cacop ready held for two cycles");
    endtask

    // memory model, answers after 0 to 3 cycles
    initial begin : mem_responder
        logic [1:0] delay;
        i_mem_rready = 1'b0;
        i_mem_rdata  = '0;
        forever begin
            @(negedge clk);
            if (rstn && o_mem_rvalid) begin
                lfsr     = lfsr_step(lfsr);
                delay[0] = lfsr[0];
                lfsr     = lfsr_step(lfsr);
                delay[1] = lfsr[0];
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #DRIVE_DLY;
                i_mem_rready = 1'b1;
                i_mem_rdata  = fill_line(o_mem_raddr);
                @(posedge clk);
                #DRIVE_DLY;
                i_mem_rready = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = addr_q.size() * 20 + 50; // cycles
        repeat (limit) @(posedge clk);
        $display("Timeout, the patterns did not finish within %0d clock cycles", limit);
        abort_run();
    end

    initial begin : main_seq
        i_req_valid  = 1'b0;
        i_req_addr   = '0;
        i_uncache    = 1'b0;
        i_flush      = 1'b0;
        i_cacop_en   = 1'b0;
        i_cacop_code = STORE_TAG;
        load_patterns();
        loaded = 1'b1;
        wait (rstn === 1'b1);
        @(negedge clk);
        check_flag(o_idle, 1'b1, "idle after reset");
        check_flag(o_req_ready, 1'b0, "response after reset");
        check_flag(o_mem_rvalid, 1'b0, "memory request after reset");
        check_flag(o_cacop_ready, 1'b0, "cacop ready after reset");
        check_flag(o_cacop_complete, 1'b0, "cacop complete after reset");
        for (int i = 0; i < addr_q.size(); i++) begin
            if (is_cacop_q[i]) begin
                run_cacop(addr_q[i], code_q[i]);
            end else begin
                run_fetch(addr_q[i], unc_q[i], flush_q[i], mem_q[i]);
            end
        end
        wait_idle();
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/10ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // released shortly after an edge, like every other input
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rstn = 1'b1;
    end

endmodule

// ==== icache_top.sv ====
`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_top import icache_pkg::*, icache_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    // fetch side
    input  logic       i_req_valid,
    input  addr_t      i_req_addr,
    input  logic       i_uncache,
    input  logic       i_flush,
    output logic       o_req_ready,
    output dword_t     o_rdata,
    output addr_t      o_pc,
    output exc_t       o_exc,
    output addr_t      o_badv,
    output logic       o_idle,
    // cache operations
    input  logic       i_cacop_en,
    input  cacop_t     i_cacop_code,
    output logic       o_cacop_ready,
    output logic       o_cacop_complete,
    // memory side
    output logic       o_mem_rvalid,
    input  logic       i_mem_rready,
    output addr_t      o_mem_raddr,
    output logic [7:0] o_mem_rlen,
    input  line_t      i_mem_rdata
);

    index_t                   rindex;
    index_t                   windex;
    tagv_t [`ICACHE_WAYS-1:0] tagv_rd;
    line_t [`ICACHE_WAYS-1:0] line_rd;
    tagv_t                    wtagv;
    line_t                    wline;
    way_mask_t                tag_we;
    way_mask_t                data_we;
    way_mask_t                victim;
    logic                     lru_we;
    logic                     lru_way;

    icache_ctrl_if ctrl_if ();

    icache_ctrl icache_ctrl_i (
        .clk              (clk),
        .rstn             (rstn),
        .i_req_valid      (i_req_valid),
        .i_flush          (i_flush),
        .i_cacop_en       (i_cacop_en),
        .i_mem_rready     (i_mem_rready),
        .i_victim         (victim),
        .o_req_ready      (o_req_ready),
        .o_idle           (o_idle),
        .o_mem_rvalid     (o_mem_rvalid),
        .o_mem_rlen       (o_mem_rlen),
        .o_cacop_ready    (o_cacop_ready),
        .o_cacop_complete (o_cacop_complete),
        .o_tag_we         (tag_we),
        .o_data_we        (data_we),
        .o_lru_we         (lru_we),
        .o_lru_way        (lru_way),
        .ctrl_if          (ctrl_if.ctrl)
    );

    icache_datapath icache_datapath_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_addr   (i_req_addr),
        .i_uncache    (i_uncache),
        .i_cacop_en   (i_cacop_en),
        .i_cacop_code (i_cacop_code),
        .i_mem_rdata  (i_mem_rdata),
        .i_tagv       (tagv_rd),
        .i_line       (line_rd),
        .o_rindex     (rindex),
        .o_windex     (windex),
        .o_wtagv      (wtagv),
        .o_wline      (wline),
        .o_rdata      (o_rdata),
        .o_pc         (o_pc),
        .o_exc        (o_exc),
        .o_badv       (o_badv),
        .o_mem_raddr  (o_mem_raddr),
        .ctrl_if      (ctrl_if.dp)
    );

    icache_lru icache_lru_i (
        .clk        (clk),
        .rstn       (rstn),
        .i_index    (windex),
        .i_we       (lru_we),
        .i_used_way (lru_way),
        .o_victim   (victim)
    );

    // one tag array and one line array per way
    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        icache_sram #(.entry_t(tagv_t)) tag_sram_i (
            .clk     (clk),
            .i_raddr (rindex),
            .i_waddr (windex),
            .i_we    (tag_we[w]),
            .i_wdata (wtagv),
            .o_rdata (tagv_rd[w])
        );

        icache_sram #(.entry_t(line_t)) data_sram_i (
            .clk     (clk),
            .i_raddr (rindex),
            .i_waddr (windex),
            .i_we    (data_we[w]),
            .i_wdata (wline),
            .o_rdata (line_rd[w])
        );
    end

endmodule

// ==== icache_ctrl.sv ====
`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_ctrl import icache_pkg::*, icache_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       i_req_valid,
    input  logic       i_flush,
    input  logic       i_cacop_en,
    input  logic       i_mem_rready,
    input  way_mask_t  i_victim,
    output logic       o_req_ready,
    output logic       o_idle,
    output logic       o_mem_rvalid,
    output logic [7:0] o_mem_rlen,
    output logic       o_cacop_ready,
    output logic       o_cacop_complete,
    output way_mask_t  o_tag_we,
    output way_mask_t  o_data_we,
    output logic       o_lru_we,
    output logic       o_lru_way,
    icache_ctrl_if.ctrl ctrl_if
);

    state_t    state;
    state_t    next_state;
    logic      discard_q;   // miss was flushed, install but stay silent
    logic      fetch_take;
    logic      lookup_hit;
    way_mask_t cacop_mask;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            discard_q <= 1'b0;
        end else if (state == MISS && i_flush) begin
            discard_q <= 1'b1;
        end else if (state == REFILL) begin
            discard_q <= 1'b0;
        end
    end

    // cacop waits for IDLE, so a fetch only goes when none is pending
    assign fetch_take = i_req_valid && !i_cacop_en;
    assign lookup_hit = ctrl_if.hit && !ctrl_if.uncache_q;

    always_comb begin
        unique case (ctrl_if.cacop_code_q)
            STORE_TAG, IDX_INV: cacop_mask = ctrl_if.cacop_way ? way_mask_t'(2'b10)
                                                               : way_mask_t'(2'b01);
            HIT_INV:            cacop_mask = ctrl_if.hit_mask;
            default:            cacop_mask = '0;
        endcase
    end

    always_comb begin
        next_state       = state;
        ctrl_if.req_we   = 1'b0;
        ctrl_if.ret_we   = 1'b0;
        ctrl_if.exc_sel  = 1'b0;
        ctrl_if.from_ret = 1'b0;
        ctrl_if.clear    = 1'b0;
        o_req_ready      = 1'b0;
        o_mem_rvalid     = 1'b0;
        o_cacop_ready    = 1'b0;
        o_cacop_complete = 1'b0;
        o_tag_we         = '0;
        o_data_we        = '0;
        o_lru_we         = 1'b0;
        o_lru_way        = 1'b0;
        unique case (state)
            IDLE: begin
                if (i_cacop_en) begin
                    ctrl_if.req_we = 1'b1;
                    o_cacop_ready  = 1'b1;
                    next_state     = CACOP;
                end else if (i_req_valid) begin
                    ctrl_if.req_we = 1'b1;
                    next_state     = LOOKUP;
                end
            end
            LOOKUP: begin
                if (i_flush) begin
                    next_state = IDLE; // dropped, no response
                end else if (ctrl_if.exc != EXC_NONE) begin
                    o_req_ready     = 1'b1;
                    ctrl_if.exc_sel = 1'b1;
                    next_state      = IDLE;
                end else if (lookup_hit) begin
                    o_req_ready    = 1'b1;
                    o_lru_we       = 1'b1;
                    o_lru_way      = ctrl_if.hit_mask[1];
                    ctrl_if.req_we = fetch_take;
                    next_state     = fetch_take ? LOOKUP : IDLE;
                end else begin
                    next_state = MISS;
                end
            end
            MISS: begin
                o_mem_rvalid = 1'b1;
                if (i_mem_rready) begin
                    ctrl_if.ret_we = 1'b1;
                    next_state     = REFILL;
                end
            end
            REFILL: begin
                ctrl_if.from_ret = 1'b1;
                o_req_ready      = !discard_q;
                if (!ctrl_if.uncache_q) begin // uncached data is never installed
                    o_tag_we  = i_victim;
                    o_data_we = i_victim;
                    o_lru_we  = 1'b1;
                    o_lru_way = i_victim[1];
                end
                next_state = IDLE;
            end
            CACOP: begin
                o_cacop_complete = 1'b1;
                if (ctrl_if.cacop_q) begin
                    ctrl_if.clear = 1'b1;
                    o_tag_we      = cacop_mask;
                end
                next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    assign o_idle     = (state == IDLE);
    assign o_mem_rlen = ctrl_if.uncache_q ? `ICACHE_RLEN_UNC : `ICACHE_RLEN_LINE;

endmodule

// ==== icache_datapath.sv ====
`timescale 1ns/10ps
`include "icache_consts.svh"

module icache_datapath import icache_pkg::*, icache_ctrl_pkg::*; (
    input  logic                         clk,
    input  logic                         rstn,
    input  addr_t                        i_req_addr,
    input  logic                         i_uncache,
    input  logic                         i_cacop_en,
    input  cacop_t                       i_cacop_code,
    input  line_t                        i_mem_rdata,
    input  tagv_t [`ICACHE_WAYS-1:0]     i_tagv,
    input  line_t [`ICACHE_WAYS-1:0]     i_line,
    output index_t                       o_rindex,
    output index_t                       o_windex,
    output tagv_t                        o_wtagv,
    output line_t                        o_wline,
    output dword_t                       o_rdata,
    output addr_t                        o_pc,
    output exc_t                         o_exc,
    output addr_t                        o_badv,
    output addr_t                        o_mem_raddr,
    icache_ctrl_if.dp                    ctrl_if
);

    addr_t     req_q;
    line_t     ret_q;
    exc_t      exc_q;
    logic      uncache_q;
    logic      cacop_q;
    cacop_t    cacop_code_q;
    tag_t      req_tag;
    way_mask_t hit_mask;
    line_t     src_line;
    dword_t    dword_sel;

    always_ff @(posedge clk) begin
        if (ctrl_if.req_we) begin
            req_q <= i_req_addr;
        end
    end

    // request control fields
    always_ff @(posedge clk) begin
        if (!rstn) begin
            uncache_q    <= 1'b0;
            cacop_q      <= 1'b0;
            cacop_code_q <= STORE_TAG;
            exc_q        <= EXC_NONE;
        end else if (ctrl_if.req_we) begin
            uncache_q    <= i_uncache;
            cacop_q      <= i_cacop_en;
            cacop_code_q <= i_cacop_code;
            // pc must be word aligned, cacop addresses are exempt
            exc_q        <= (i_req_addr[1:0] != 2'b00 && !i_cacop_en) ? EXC_ADEF : EXC_NONE;
        end
    end

    // whole line in one beat
    always_ff @(posedge clk) begin
        if (ctrl_if.ret_we) begin
            ret_q <= i_mem_rdata;
        end
    end

    assign req_tag  = req_q[`ICACHE_OFFSET_W + `ICACHE_INDEX_W +: `ICACHE_TAG_W];
    assign o_windex = req_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    // the next request is read while the current one answers
    assign o_rindex = ctrl_if.req_we ? i_req_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W]
                                     : o_windex;

    assign o_wtagv = ctrl_if.clear ? tagv_t'('0) : tagv_t'{valid: 1'b1, tag: req_tag};
    assign o_wline = ret_q;

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_mask[w] = i_tagv[w].valid && (i_tagv[w].tag == req_tag);
        end
    end

    always_comb begin
        src_line = ctrl_if.from_ret ? ret_q : i_line[hit_mask[1]];
        if (uncache_q) begin
            dword_sel = ret_q[`ICACHE_DWORD_W-1:0]; // uncached address is already dword aligned
        end else begin
            dword_sel = src_line[req_q[3] * `ICACHE_DWORD_W +: `ICACHE_DWORD_W];
        end
    end

    assign o_rdata = ctrl_if.exc_sel ? {`ICACHE_NOP, `ICACHE_NOP} : dword_sel;
    assign o_pc    = req_q;
    assign o_exc   = ctrl_if.exc_sel ? exc_q : EXC_NONE;
    assign o_badv  = ctrl_if.exc_sel ? req_q : '0;

    // dword for uncached, whole line otherwise
    assign o_mem_raddr = uncache_q ? {req_q[31:3], 3'b000}
                                   : {req_q[31:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

    assign ctrl_if.hit_mask     = hit_mask;
    assign ctrl_if.hit          = |hit_mask;
    assign ctrl_if.exc          = exc_q;
    assign ctrl_if.uncache_q    = uncache_q;
    assign ctrl_if.cacop_q      = cacop_q;
    assign ctrl_if.cacop_code_q = cacop_code_q;
    assign ctrl_if.cacop_way    = req_q[0];

endmodule

// ==== icache_lru.sv ====
`timescale 1ns/10ps

module icache_lru import icache_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  index_t    i_index,
    input  logic      i_we,
    input  logic      i_used_way,
    output way_mask_t o_victim
);

    localparam int SETS = 2 ** $bits(index_t);

    // 1 means way 1 was touched last
    logic [SETS-1:0] last_used_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            last_used_q <= '0;
        end else if (i_we) begin
            last_used_q[i_index] <= i_used_way;
        end
    end

    // victim is the way not used last
    assign o_victim = last_used_q[i_index] ? way_mask_t'(2'b01) : way_mask_t'(2'b10);

endmodule

// ==== icache_sram.sv ====
`timescale 1ns/10ps

module icache_sram import icache_pkg::*; #(
    parameter type entry_t = logic
) (
    input  logic   clk,
    input  index_t i_raddr,
    input  index_t i_waddr,
    input  logic   i_we,
    input  entry_t i_wdata,
    output entry_t o_rdata
);

    localparam int DEPTH = 2 ** $bits(index_t);

    // starts cleared, so every tag comes up invalid
    entry_t mem [DEPTH] = '{default: '0};
    entry_t rdata_q = '0;

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        rdata_q <= mem[i_raddr]; // old contents on a same-index write
    end

    assign o_rdata = rdata_q;

endmodule

// ==== icache_ctrl_if.sv ====
`timescale 1ns/10ps

interface icache_ctrl_if import icache_pkg::*, icache_ctrl_pkg::*; ();

    // strobes from the FSM
    logic      req_we;       // capture request
    logic      ret_we;       // capture memory line
    logic      exc_sel;      // answer with the buffered exception
    logic      from_ret;     // data from return buffer
    logic      clear;        // write an invalid tag

    // status back from the datapath
    logic      hit;
    way_mask_t hit_mask;
    exc_t      exc;
    logic      uncache_q;
    logic      cacop_q;
    cacop_t    cacop_code_q;
    logic      cacop_way;    // address bit 0 picks the way

    modport ctrl (
        output req_we, ret_we, exc_sel, from_ret, clear,
        input  hit, hit_mask, exc, uncache_q, cacop_q, cacop_code_q, cacop_way
    );

    modport dp (
        input  req_we, ret_we, exc_sel, from_ret, clear,
        output hit, hit_mask, exc, uncache_q, cacop_q, cacop_code_q, cacop_way
    );

endinterface

// ==== icache_ctrl_pkg.sv ====
`include "icache_consts.svh"

package icache_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOOKUP = 3'd1,
        MISS   = 3'd2,
        REFILL = 3'd3,
        CACOP  = 3'd4
    } state_t;

    typedef enum logic [1:0] {
        STORE_TAG = 2'b00,
        IDX_INV   = 2'b01,
        HIT_INV   = 2'b10
    } cacop_t;

    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        EXC_ADEF = `ICACHE_EXC_ADEF
    } exc_t;

endpackage

// ==== icache_pkg.sv ====
`include "icache_consts.svh"

package icache_pkg;

    typedef logic [31:0] addr_t;

    typedef logic [`ICACHE_INDEX_W-1:0] index_t;

    typedef logic [`ICACHE_TAG_W-1:0] tag_t;

    // valid bit on top of the tag
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    typedef logic [`ICACHE_LINE_W-1:0] line_t;

    typedef logic [`ICACHE_DWORD_W-1:0] dword_t;

    // one bit per way
    typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

endpackage

// ==== icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// geometry
`define ICACHE_INDEX_W 4     // 16 sets
`define ICACHE_OFFSET_W 4    // 16 bytes per line
`define ICACHE_TAG_W (32 - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)
`define ICACHE_LINE_W 128
`define ICACHE_DWORD_W 64    // fetch width, two instructions
`define ICACHE_WAYS 2

// andi r0, r0, 0
`define ICACHE_NOP 32'h0340_0000

// fetch address error
`define ICACHE_EXC_ADEF 7'h08

// beats minus one on the memory side
`define ICACHE_RLEN_LINE 8'd0
`define ICACHE_RLEN_UNC 8'd0

`endif
